//--- vlog.f
+incdir+hw
+incdir+dv
hw/cpu_pkg.sv
hw/spm.sv
hw/gpr.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/cpu_top.sv
dv/cpu_tb.sv

//--- run.sh
#!/bin/sh
# build the cpu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/cpu_tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Finished with errors" sim.log; then
    exit 1
fi
exit 0

//--- dv/cpu_tb_ref.svh
`ifndef CPU_TB_REF_SVH
`define CPU_TB_REF_SVH

function automatic word_t enc_r(opcode_e op, int rd, int rs1, int rs2);
    return {op, 5'(rd), 5'(rs1), 5'(rs2), 11'd0};
endfunction

function automatic word_t enc_i(opcode_e op, int rd, int rs1, int imm);
    return {op, 5'(rd), 5'(rs1), 16'(imm)};
endfunction

function automatic int dbyte(int k);
    return (DATA_BASE + k) * 4;   // byte address of data word k
endfunction

function automatic void emit(word_t w);
    image[plen] = w;
    plen++;
endfunction

// two nops behind, so any later instruction may use the result
function automatic void emit_spaced(word_t w);
    emit(w);
    emit(NOP_INSN);
    emit(NOP_INSN);
endfunction

function automatic void init_image();
    for (int i = 0; i < MEM_N; i++) begin
        image[i] = (word_t'(i) * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    end
    for (int i = 0; i < DATA_N; i++) begin
        image[DATA_BASE + i] = $urandom;
    end
    plen = 0;
endfunction

function automatic void build_alu();
    init_image();
    emit_spaced(enc_i(OP_ADDI, 1, 0, 16'h1234));
    emit_spaced(enc_i(OP_ADDI, 2, 0, -7));
    emit_spaced(enc_i(OP_ADDI, 3, 0, 5));
    emit_spaced(enc_i(OP_ADDI, 13, 0, 37));   // only low 5 bits count
    emit_spaced(enc_r(OP_ADD, 4, 1, 2));
    emit_spaced(enc_r(OP_SUB, 5, 1, 2));
    emit_spaced(enc_r(OP_AND, 6, 1, 2));
    emit_spaced(enc_r(OP_OR, 7, 1, 2));
    emit_spaced(enc_r(OP_XOR, 8, 1, 2));
    emit_spaced(enc_r(OP_SHL, 9, 1, 3));
    emit_spaced(enc_r(OP_SHR, 10, 2, 13));
    emit_spaced(enc_i(OP_ADDI, 0, 1, 99));    // write to r0 is lost
    emit_spaced(enc_r(OP_ADD, 11, 0, 1));
    emit_spaced(enc_i(OP_ADDI, 12, 2, -300));
    for (int r = 0; r <= 13; r++) begin
        emit_spaced(enc_i(OP_STW, r, 0, dbyte(r)));
    end
    emit(enc_i(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_ldst();
    init_image();
    emit_spaced(enc_i(OP_LDW, 1, 0, dbyte(0)));
    emit_spaced(enc_i(OP_LDW, 2, 0, dbyte(1)));
    emit_spaced(enc_i(OP_ADDI, 5, 0, dbyte(2)));
    emit_spaced(enc_i(OP_LDW, 3, 5, 4));
    emit_spaced(enc_r(OP_ADD, 4, 1, 2));
    emit_spaced(enc_r(OP_XOR, 6, 3, 1));
    emit_spaced(enc_i(OP_STW, 4, 0, dbyte(16)));
    emit_spaced(enc_i(OP_STW, 6, 5, 60));
    emit_spaced(enc_i(OP_STW, 3, 0, dbyte(18)));
    emit_spaced(enc_i(OP_STW, 1, 5, -8));     // back onto word 0
    emit(enc_i(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_branch(int loop_n);
    init_image();
    emit(enc_i(OP_ADDI, 1, 0, loop_n));   // 0
    emit(NOP_INSN);
    emit(NOP_INSN);
    emit(enc_i(OP_ADDI, 1, 1, -1));       // 3 loop top
    emit(enc_i(OP_ADDI, 2, 2, 3));
    emit(NOP_INSN);
    emit(enc_i(OP_BNE, 0, 1, -4));        // 6 back to 3
    emit(enc_i(OP_ADDI, 3, 3, 1));        // delay slot, every pass
    emit(NOP_INSN);
    emit(NOP_INSN);
    emit(enc_i(OP_BEQ, 0, 1, 2));         // 10 taken, to 13
    emit(enc_i(OP_ADDI, 4, 0, 77));       // delay slot
    emit(enc_i(OP_ADDI, 5, 0, 55));       // skipped
    emit(enc_i(OP_BEQ, 0, 3, 2));         // 13 not taken
    emit(enc_i(OP_ADDI, 6, 0, 11));
    emit(enc_i(OP_ADDI, 7, 0, 22));
    emit(NOP_INSN);
    emit(NOP_INSN);
    for (int r = 1; r <= 7; r++) begin
        emit_spaced(enc_i(OP_STW, r, 0, dbyte(r)));
    end
    emit(enc_i(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_misalign();
    init_image();
    emit_spaced(enc_i(OP_ADDI, 1, 0, 16'h3333));
    emit_spaced(enc_i(OP_ADDI, 2, 0, 16'h4444));
    emit_spaced(enc_i(OP_LDW, 1, 0, dbyte(0) + 1));   // suppressed, r1 unchanged
    emit_spaced(enc_i(OP_STW, 2, 0, dbyte(2) + 2));   // suppressed
    emit_spaced(enc_i(OP_STW, 1, 0, dbyte(4)));
    emit_spaced(enc_i(OP_STW, 2, 0, dbyte(5)));
    emit(enc_i(OP_HALT, 0, 0, 0));
endfunction

function automatic void build_random(int n_ops);
    int last_wr [16];
    int rd;
    int ra;
    int rb;
    int pick;
    init_image();
    for (int r = 0; r < 16; r++) begin
        last_wr[r] = -8;
    end
    for (int r = 1; r < 16; r++) begin
        emit(enc_i(OP_ADDI, r, 0, $urandom));
        last_wr[r] = plen - 1;
    end
    for (int k = 0; k < n_ops; k++) begin
        rd = $urandom % 16;
        ra = $urandom % 16;
        rb = $urandom % 16;
        pick = $urandom % 8;
        // pad until both sources are written back
        while (plen - last_wr[ra] < 3 || plen - last_wr[rb] < 3) begin
            emit(NOP_INSN);
        end
        if (pick == 7) begin
            emit(enc_i(OP_ADDI, rd, ra, $urandom));
        end else begin
            emit(enc_r(opcode_e'(OP_ADD + pick), rd, ra, rb));
        end
        last_wr[rd] = plen - 1;
    end
    for (int r = 0; r < 16; r++) begin
        while (plen - last_wr[r] < 3) begin
            emit(NOP_INSN);
        end
        emit(enc_i(OP_STW, r, 0, dbyte(r)));
    end
    emit(enc_i(OP_HALT, 0, 0, 0));
endfunction

// ISA interpreter over ref_mem, returns the expected misalign flag
function automatic logic run_reference();
    word_t regs [32];
    word_t insn;
    word_t a;
    word_t b;
    word_t c;
    word_t addr;
    int pc;
    int npc;
    int nnpc;
    int imm;
    logic [5:0] op;
    logic mis;
    mis = 1'b0;
    pc = `CPU_RESET_PC;
    npc = pc + 1;
    for (int r = 0; r < 32; r++) begin
        regs[r] = '0;
    end
    for (int step = 0; step < RUN_MAX; step++) begin
        insn = ref_mem[pc];
        op = insn[31:26];
        a = regs[insn[20:16]];
        b = regs[insn[15:11]];
        c = regs[insn[25:21]];   // store data and branch operand
        imm = {{16{insn[15]}}, insn[15:0]};
        nnpc = (npc + 1) % MEM_N;
        if (op == OP_HALT) break;
        case (op)
            OP_ADD:  regs[insn[25:21]] = a + b;
            OP_SUB:  regs[insn[25:21]] = a - b;
            OP_AND:  regs[insn[25:21]] = a & b;
            OP_OR:   regs[insn[25:21]] = a | b;
            OP_XOR:  regs[insn[25:21]] = a ^ b;
            OP_SHL:  regs[insn[25:21]] = a << b[4:0];
            OP_SHR:  regs[insn[25:21]] = a >> b[4:0];
            OP_ADDI: regs[insn[25:21]] = a + imm;
            OP_LDW: begin
                addr = a + imm;
                if (addr[1:0] != 2'b00) begin
                    mis = 1'b1;
                end else begin
                    regs[insn[25:21]] = ref_mem[addr[`CPU_SPM_AW+1:2]];
                end
            end
            OP_STW: begin
                addr = a + imm;
                if (addr[1:0] != 2'b00) begin
                    mis = 1'b1;
                end else begin
                    ref_mem[addr[`CPU_SPM_AW+1:2]] = c;
                end
            end
            OP_BEQ: if (a == c) nnpc = (pc + 1 + imm) & (MEM_N - 1);
            OP_BNE: if (a != c) nnpc = (pc + 1 + imm) & (MEM_N - 1);
            default: ;
        endcase
        regs[0] = '0;
        pc = npc;
        npc = nnpc;   // delay slot runs before the target
    end
    return mis;
endfunction

`endif

//--- dv/cpu_tb.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int MEM_N = 2**`CPU_SPM_AW;
    localparam int DATA_BASE = 256;   // word index of the data area
    localparam int DATA_N = 64;
    localparam int PROG_MAX = 256;
    localparam int LOOP_MAX = 16;
    localparam int RUN_MAX = PROG_MAX * LOOP_MAX;   // cycles per program
    localparam int N_TESTS = 25;
    localparam longint WATCHDOG_NS = longint'(N_TESTS) * (RUN_MAX + MEM_N + DATA_N + 16) * 20
                                     + 10000;

    logic clk;
    logic rst;
    logic cpu_en;
    logic test_spm_en;
    logic test_spm_we;
    logic [`CPU_SPM_AW-1:0] test_spm_addr;
    word_t test_spm_wdata;
    word_t test_spm_rdata;
    logic halted;
    logic misalign;

    word_t image [MEM_N];
    word_t ref_mem [MEM_N];
    word_t dut_mem [DATA_N];
    int    plen;
    logic  exp_mis;
    int    errors;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    logic  check_busy;
    event  check_req;

    `include "cpu_tb_ref.svh"

    cpu_top u_dut (
        .clk(clk), .rst(rst), .cpu_en(cpu_en),
        .test_spm_en(test_spm_en), .test_spm_we(test_spm_we),
        .test_spm_addr(test_spm_addr), .test_spm_wdata(test_spm_wdata),
        .test_spm_rdata(test_spm_rdata), .halted(halted), .misalign(misalign)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic report_mismatch(string sig, word_t exp, word_t got);
        $display("Mismatch at %0t: %s expected %08h got %08h", $time, sig, exp, got);
        test_errors++;
    endtask

    task automatic write_word(int addr, word_t data);
        test_spm_en = 1'b1;
        test_spm_we = 1'b1;
        test_spm_addr = addr[`CPU_SPM_AW-1:0];
        test_spm_wdata = data;
        tick();
        test_spm_en = 1'b0;
        test_spm_we = 1'b0;
    endtask

    task automatic read_word(int addr, output word_t data);
        test_spm_en = 1'b1;
        test_spm_addr = addr[`CPU_SPM_AW-1:0];
        tick();   // rdata valid one cycle after the request
        test_spm_en = 1'b0;
        data = test_spm_rdata;
    endtask

    task automatic run_program();
        int cycles;
        cycles = 0;
        cpu_en = 1'b1;
        while (halted !== 1'b1 && cycles < RUN_MAX) begin
            tick();
            cycles++;
        end
        if (halted !== 1'b1) begin
            $display("core did not halt within %0d cycles, at %0t", RUN_MAX, $time);
            test_errors++;
        end
        repeat (4) tick();   // let the pipeline drain
        cpu_en = 1'b0;
        tick();
    endtask

    task automatic finish_test(string name);
        tests_run++;
        errors += test_errors;
        if (test_errors != 0) tests_failed++;
        $display("test %s: %s, %0d errors", name,
                 (test_errors == 0) ? "passed" : "FAILED", test_errors);
    endtask

    task automatic run_test(string name);
        word_t got;
        test_errors = 0;
        ref_mem = image;
        exp_mis = run_reference();
        rst = 1'b1;
        repeat (2) tick();
        rst = 1'b0;
        for (int i = 0; i < MEM_N; i++) begin
            write_word(i, image[i]);
        end
        run_program();
        for (int i = 0; i < DATA_N; i++) begin
            read_word(DATA_BASE + i, got);
            dut_mem[i] = got;
        end
        check_busy = 1'b1;
        -> check_req;
        wait (!check_busy);
        finish_test(name);
    endtask

    // compares the read-back data area and flags against the reference
    always begin : compare_proc
        @(check_req);
        if (misalign !== exp_mis) begin
            report_mismatch("misalign", word_t'(exp_mis), word_t'(misalign));
        end
        for (int i = 0; i < DATA_N; i++) begin
            if (dut_mem[i] !== ref_mem[DATA_BASE + i]) begin
                report_mismatch($sformatf("test_spm_rdata[%0d]", DATA_BASE + i),
                                ref_mem[DATA_BASE + i], dut_mem[i]);
            end
        end
        check_busy = 1'b0;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired at %0t, the run did not complete", $time);
        $display("Finished with errors");
        $finish;
    end

    initial begin : main_proc
        word_t pat [8];
        word_t got;
        void'($urandom(32'hfb3dcb03));
        rst = 1'b1;
        cpu_en = 1'b0;
        test_spm_en = 1'b0;
        test_spm_we = 1'b0;
        test_spm_addr = '0;
        test_spm_wdata = '0;
        check_busy = 1'b0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        // flags after reset, then a test port round trip
        test_errors = 0;
        if (halted !== 1'b0) report_mismatch("halted", 32'd0, word_t'(halted));
        if (misalign !== 1'b0) report_mismatch("misalign", 32'd0, word_t'(misalign));
        for (int i = 0; i < 8; i++) begin
            pat[i] = $urandom;
            write_word(i * 97 + 3, pat[i]);
        end
        for (int i = 0; i < 8; i++) begin
            read_word(i * 97 + 3, got);
            if (got !== pat[i]) begin
                report_mismatch($sformatf("test_spm_rdata[%0d]", i * 97 + 3), pat[i], got);
            end
        end
        finish_test("test_port");

        build_alu();
        run_test("alu");
        build_ldst();
        run_test("load_store");
        build_branch(3 + $urandom % 10);
        run_test("branch");
        build_misalign();
        run_test("misalign");
        for (int n = 0; n < 20; n++) begin
            build_random(24);
            run_test($sformatf("random_%0d", n));
        end

        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- hw/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  logic                   test_spm_en,
    input  logic                   test_spm_we,
    input  logic [`CPU_SPM_AW-1:0] test_spm_addr,
    input  word_t                  test_spm_wdata,
    output word_t                  test_spm_rdata,
    output logic                   halted,
    output logic                   misalign
);

    if_id_t   if_id;
    id_ex_t   id_ex;
    ex_mem_t  ex_mem;
    mem_wb_t  mem_wb;
    logic     imem_en;
    pc_t      imem_addr;
    word_t    imem_rdata;
    logic     branch_taken;
    pc_t      branch_target;
    logic     halt_seen;
    reg_idx_t gpr_raddr0;
    reg_idx_t gpr_raddr1;
    word_t    gpr_rdata0;
    word_t    gpr_rdata1;
    logic     dmem_en;
    logic     dmem_we;
    logic [`CPU_SPM_AW-1:0] dmem_addr;
    word_t    dmem_wdata;
    word_t    dmem_rdata;
    logic     spm_b_en;
    logic     spm_b_we;
    logic [`CPU_SPM_AW-1:0] spm_b_addr;
    word_t    spm_b_wdata;

    fetch_stage u_fetch (
        .clk(clk), .rst(rst), .cpu_en(cpu_en),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .halt_seen(halt_seen), .imem_en(imem_en), .imem_addr(imem_addr),
        .imem_rdata(imem_rdata), .if_id(if_id), .halted(halted)
    );

    decode_stage u_decode (
        .clk(clk), .rst(rst), .cpu_en(cpu_en), .if_id(if_id),
        .gpr_rdata0(gpr_rdata0), .gpr_rdata1(gpr_rdata1),
        .gpr_raddr0(gpr_raddr0), .gpr_raddr1(gpr_raddr1),
        .branch_taken(branch_taken), .branch_target(branch_target),
        .halt_seen(halt_seen), .id_ex(id_ex)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .cpu_en(cpu_en), .id_ex(id_ex), .ex_mem(ex_mem)
    );

    memory_stage u_memory (
        .clk(clk), .rst(rst), .cpu_en(cpu_en), .ex_mem(ex_mem),
        .dmem_en(dmem_en), .dmem_we(dmem_we), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata),
        .mem_wb(mem_wb), .misalign(misalign)
    );

    gpr u_gpr (
        .clk(clk), .rst(rst),
        .we(mem_wb.we), .waddr(mem_wb.rd), .wdata(mem_wb.wdata),
        .raddr0(gpr_raddr0), .raddr1(gpr_raddr1),
        .rdata0(gpr_rdata0), .rdata1(gpr_rdata1)
    );

    // test port owns the data port while the core is off
    assign spm_b_en    = cpu_en ? dmem_en    : test_spm_en;
    assign spm_b_we    = cpu_en ? dmem_we    : test_spm_we;
    assign spm_b_addr  = cpu_en ? dmem_addr  : test_spm_addr;
    assign spm_b_wdata = cpu_en ? dmem_wdata : test_spm_wdata;

    spm u_spm (
        .clk(clk),
        .a_en(imem_en), .a_addr(imem_addr), .a_rdata(imem_rdata),
        .b_en(spm_b_en), .b_we(spm_b_we), .b_addr(spm_b_addr),
        .b_wdata(spm_b_wdata), .b_rdata(dmem_rdata)
    );

    assign test_spm_rdata = dmem_rdata;

    a_test_port_idle: assert property (
        @(posedge clk) disable iff (rst) cpu_en |-> !test_spm_en);

endmodule

//--- hw/memory_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module memory_stage import cpu_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   cpu_en,
    input  ex_mem_t                ex_mem,
    output logic                   dmem_en,
    output logic                   dmem_we,
    output logic [`CPU_SPM_AW-1:0] dmem_addr,
    output word_t                  dmem_wdata,
    input  word_t                  dmem_rdata,
    output mem_wb_t                mem_wb,
    output logic                   misalign
);

    logic    access;
    logic    aligned;
    mem_wb_t wb_q;
    mem_op_e mem_op_q;

    assign access  = (ex_mem.mem_op != MEM_NONE);
    assign aligned = (ex_mem.result[1:0] == 2'b00);

    assign dmem_en    = cpu_en && access && aligned;
    assign dmem_we    = dmem_en && (ex_mem.mem_op == MEM_STORE);
    assign dmem_addr  = ex_mem.result[`CPU_SPM_AW+1:2];   // byte to word index
    assign dmem_wdata = ex_mem.st_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_q     <= '0;
            mem_op_q <= MEM_NONE;
            misalign <= 1'b0;
        end else if (cpu_en) begin
            wb_q.rd    <= ex_mem.rd;
            wb_q.we    <= ex_mem.we && (aligned || !access);   // drop suppressed load
            wb_q.wdata <= ex_mem.result;
            mem_op_q   <= ex_mem.mem_op;
            if (access && !aligned) misalign <= 1'b1;
        end
    end

    // load data arrives one cycle after the request
    always_comb begin
        mem_wb = wb_q;
        if (mem_op_q == MEM_LOAD) mem_wb.wdata = dmem_rdata;
    end

    // a suppressed load leaves its destination alone
    a_no_wb_on_misaligned_load: assert property (
        @(posedge clk) disable iff (rst)
        (cpu_en && ex_mem.mem_op == MEM_LOAD && !aligned) |=> !mem_wb.we);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module execute_stage import cpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    cpu_en,
    input  id_ex_t  id_ex,
    output ex_mem_t ex_mem
);

    word_t result;

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    result = id_ex.opa + id_ex.opb;
            ALU_SUB:    result = id_ex.opa - id_ex.opb;
            ALU_AND:    result = id_ex.opa & id_ex.opb;
            ALU_OR:     result = id_ex.opa | id_ex.opb;
            ALU_XOR:    result = id_ex.opa ^ id_ex.opb;
            ALU_SHL:    result = id_ex.opa << id_ex.opb[4:0];
            ALU_SHR:    result = id_ex.opa >> id_ex.opb[4:0];   // logical
            ALU_PASS_B: result = id_ex.opb;
            default:    result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem <= '0;
        end else if (cpu_en) begin
            ex_mem.result  <= result;
            ex_mem.rd      <= id_ex.rd;
            ex_mem.we      <= id_ex.we;
            ex_mem.mem_op  <= id_ex.mem_op;
            ex_mem.st_data <= id_ex.st_data;
        end
    end

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module decode_stage import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     cpu_en,
    input  if_id_t   if_id,
    input  word_t    gpr_rdata0,
    input  word_t    gpr_rdata1,
    output reg_idx_t gpr_raddr0,
    output reg_idx_t gpr_raddr1,
    output logic     branch_taken,
    output pc_t      branch_target,
    output logic     halt_seen,
    output id_ex_t   id_ex
);

    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    word_t    imm_ext;
    logic     uses_rd;
    id_ex_t   id_ex_d;

    assign op      = opcode_e'(if_id.insn[31:26]);
    assign rd      = if_id.insn[25:21];
    assign rs1     = if_id.insn[20:16];
    assign rs2     = if_id.insn[15:11];
    assign imm_ext = {{16{if_id.insn[15]}}, if_id.insn[15:0]};

    // stores and branches take their second register from the rd field
    assign uses_rd    = (op == OP_STW) || (op == OP_BEQ) || (op == OP_BNE);
    assign gpr_raddr0 = rs1;
    assign gpr_raddr1 = uses_rd ? rd : rs2;

    assign branch_target = if_id.pc + 1'b1 + imm_ext[`CPU_SPM_AW-1:0];

    always_comb begin
        id_ex_d         = '0;
        id_ex_d.alu_op  = ALU_PASS_B;
        id_ex_d.opa     = gpr_rdata0;
        id_ex_d.opb     = gpr_rdata1;
        id_ex_d.rd      = rd;
        id_ex_d.mem_op  = MEM_NONE;
        id_ex_d.st_data = gpr_rdata1;
        branch_taken    = 1'b0;
        halt_seen       = 1'b0;
        case (op)
            OP_ADD: begin id_ex_d.alu_op = ALU_ADD; id_ex_d.we = 1'b1; end
            OP_SUB: begin id_ex_d.alu_op = ALU_SUB; id_ex_d.we = 1'b1; end
            OP_AND: begin id_ex_d.alu_op = ALU_AND; id_ex_d.we = 1'b1; end
            OP_OR:  begin id_ex_d.alu_op = ALU_OR;  id_ex_d.we = 1'b1; end
            OP_XOR: begin id_ex_d.alu_op = ALU_XOR; id_ex_d.we = 1'b1; end
            OP_SHL: begin id_ex_d.alu_op = ALU_SHL; id_ex_d.we = 1'b1; end
            OP_SHR: begin id_ex_d.alu_op = ALU_SHR; id_ex_d.we = 1'b1; end
            OP_ADDI, OP_LDW: begin
                id_ex_d.alu_op = ALU_ADD;
                id_ex_d.opb    = imm_ext;
                id_ex_d.we     = 1'b1;
                if (op == OP_LDW) id_ex_d.mem_op = MEM_LOAD;
            end
            OP_STW: begin
                id_ex_d.alu_op = ALU_ADD;   // base + offset
                id_ex_d.opb    = imm_ext;
                id_ex_d.mem_op = MEM_STORE;
            end
            OP_BEQ:  branch_taken = (gpr_rdata0 == gpr_rdata1);
            OP_BNE:  branch_taken = (gpr_rdata0 != gpr_rdata1);
            OP_HALT: halt_seen = 1'b1;
            default: ;   // nop and unknown opcodes
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex <= '0;
        end else if (cpu_en) begin
            id_ex <= id_ex_d;
        end
    end

endmodule

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module fetch_stage import cpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   cpu_en,
    input  logic   branch_taken,
    input  pc_t    branch_target,
    input  logic   halt_seen,
    output logic   imem_en,
    output pc_t    imem_addr,
    input  word_t  imem_rdata,
    output if_id_t if_id,
    output logic   halted
);

    pc_t  pc;
    pc_t  fetch_pc_q;   // pc of the word now on imem_rdata
    logic fetch_vld_q;

    // stop issuing as soon as decode sees HALT
    assign imem_en   = cpu_en && !halted && !halt_seen;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc          <= pc_t'(`CPU_RESET_PC);
            fetch_pc_q  <= pc_t'(`CPU_RESET_PC);
            fetch_vld_q <= 1'b0;
            halted      <= 1'b0;
        end else if (cpu_en) begin
            if (imem_en) begin
                pc <= branch_taken ? branch_target : pc + 1'b1;
            end
            fetch_pc_q  <= pc;
            fetch_vld_q <= imem_en;
            if (halt_seen) halted <= 1'b1;
        end
    end

    assign if_id.pc   = fetch_pc_q;
    assign if_id.insn = fetch_vld_q ? imem_rdata : NOP_INSN;   // bubble when idle

    // nothing fetched behind HALT reaches decode
    a_no_decode_after_halt: assert property (
        @(posedge clk) disable iff (rst) halted |-> (if_id.insn == NOP_INSN));

endmodule

//--- hw/gpr.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module gpr import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t waddr,
    input  word_t    wdata,
    input  reg_idx_t raddr0,
    input  reg_idx_t raddr1,
    output word_t    rdata0,
    output word_t    rdata1
);

    word_t regs [`CPU_GPR_N];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `CPU_GPR_N; i++) regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero; same-cycle write passes through
    assign rdata0 = (raddr0 == '0) ? '0 :
                    (we && waddr == raddr0) ? wdata : regs[raddr0];
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];

endmodule

//--- hw/spm.sv
`timescale 1ns/1ps
`include "cpu_config.svh"

module spm (
    input  logic                   clk,
    // instruction port, read only
    input  logic                   a_en,
    input  logic [`CPU_SPM_AW-1:0] a_addr,
    output logic [`CPU_DATA_W-1:0] a_rdata,
    // data port
    input  logic                   b_en,
    input  logic                   b_we,
    input  logic [`CPU_SPM_AW-1:0] b_addr,
    input  logic [`CPU_DATA_W-1:0] b_wdata,
    output logic [`CPU_DATA_W-1:0] b_rdata
);

    logic [`CPU_DATA_W-1:0] mem [2**`CPU_SPM_AW];

    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];   // holds when idle
        end
    end

    always_ff @(posedge clk) begin
        if (b_en) begin
            if (b_we) mem[b_addr] <= b_wdata;
            b_rdata <= mem[b_addr];   // read before write
        end
    end

endmodule

//--- hw/cpu_pkg.sv
`include "cpu_config.svh"

package cpu_pkg;

    typedef logic [`CPU_DATA_W-1:0] word_t;
    typedef logic [`CPU_SPM_AW-1:0] pc_t;      // word address
    typedef logic [$clog2(`CPU_GPR_N)-1:0] reg_idx_t;

    // insn[31:26] opcode, [25:21] rd, [20:16] rs1, [15:11] rs2, [15:0] imm
    typedef enum logic [5:0] {
        OP_NOP  = 6'd0,
        OP_ADD  = 6'd1,
        OP_SUB  = 6'd2,
        OP_AND  = 6'd3,
        OP_OR   = 6'd4,
        OP_XOR  = 6'd5,
        OP_SHL  = 6'd6,
        OP_SHR  = 6'd7,
        OP_ADDI = 6'd8,
        OP_LDW  = 6'd9,
        OP_STW  = 6'd10,
        OP_BEQ  = 6'd11,
        OP_BNE  = 6'd12,
        OP_HALT = 6'd13
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SHL,
        ALU_SHR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

    localparam word_t NOP_INSN = '0;   // all-zero word is a nop

    typedef struct packed {
        pc_t   pc;
        word_t insn;
    } if_id_t;

    typedef struct packed {
        alu_op_e  alu_op;
        word_t    opa;
        word_t    opb;
        reg_idx_t rd;
        logic     we;
        mem_op_e  mem_op;
        word_t    st_data;
    } id_ex_t;

    typedef struct packed {
        word_t    result;
        reg_idx_t rd;
        logic     we;
        mem_op_e  mem_op;
        word_t    st_data;
    } ex_mem_t;

    typedef struct packed {
        reg_idx_t rd;
        logic     we;
        word_t    wdata;
    } mem_wb_t;

endpackage

//--- hw/cpu_config.svh
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and instruction width
`define CPU_DATA_W 32

// register file depth
`define CPU_GPR_N 32

// spm word index width, 1024 words
`define CPU_SPM_AW 10

// first fetch address in words
`define CPU_RESET_PC 0

`endif
